// File: files.f
verilog/useq_pkg.sv
verilog/op_decode.sv
verilog/ucode_rom.sv
verilog/step_counter.sv
verilog/useq_fsm.sv
verilog/useq_datapath.sv
verilog/apb_host_if.sv
verilog/useq_top.sv
verification/clk_gen.sv
verification/useq_assertions.sv
verification/useq_tb.sv

// File: verification/useq_tb.sv
//****************************************
// directed testbench for the sequencer
// APB access tasks, compare tasks
// reset, ALU, swap/delay, interrupt, halt
//****************************************
`timescale 1ns/1ps
`default_nettype none

module useq_tb import useq_pkg::*; ();

    localparam int TIMEOUT = 2000;  // cycles per wait loop

    logic        clk;
    logic        rst;
    logic        rst_req;
    logic        nmi_n;
    logic        irq_n;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // expected state of the datapath
    logic [7:0]  m_a;
    logic [7:0]  m_b;
    logic        m_z;
    logic        m_c;
    logic        m_i;

    clk_gen u_clk_gen (.rst_req(rst_req), .clk(clk), .rst(rst));

    useq_top #(.DLY_W(8)) u_useq_top (
        .clk(clk), .rst(rst), .nmi_n(nmi_n), .irq_n(irq_n), .paddr(paddr),
        .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    bind useq_top useq_assertions u_assertions (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
        .pslverr(pslverr), .busy(busy), .halted(halted), .intvec(intvec),
        .step(step), .state(u_fsm.state)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    // a bound assertion failure ends the run
    always @(negedge clk) begin
        if (u_useq_top.u_assertions.fail_cnt != 0)
            abort_run("a bound assertion failed");
    end

    // one APB transfer with pready sampled at negedge
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err, output int waits);
        int n;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;  // access phase
        n = 0;
        @(negedge clk);
        while (!pready && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (!pready) abort_run("APB access phase never saw pready");
        rdata = prdata;
        err   = pslverr;
        waits = n;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err, output int waits);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err, waits);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        logic err;
        int   waits;
        apb_access(1'b0, addr, 32'd0, data, err, waits);
        if (err) abort_run("read returned a slave error");
    endtask

    task automatic check_err(input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAILED pslverr: got 0x%0h, expected 0x%0h", got, exp));
    endtask

    task automatic check_acc(input logic [7:0] exp_a, input logic [7:0] exp_b);
        logic [31:0] rd;
        apb_read(REG_ACC, rd);
        if (rd[7:0] !== exp_a)
            abort_run($sformatf("FAILED acc_a: got 0x%02h, expected 0x%02h", rd[7:0], exp_a));
        if (rd[15:8] !== exp_b)
            abort_run($sformatf("FAILED acc_b: got 0x%02h, expected 0x%02h", rd[15:8], exp_b));
    endtask

    task automatic check_flags(input logic exp_z, input logic exp_c, input logic exp_i);
        logic [31:0] rd;
        apb_read(REG_STATUS, rd);
        if (rd[3] !== exp_z)
            abort_run($sformatf("FAILED z: got 0x%0h, expected 0x%0h", rd[3], exp_z));
        if (rd[4] !== exp_c)
            abort_run($sformatf("FAILED c: got 0x%0h, expected 0x%0h", rd[4], exp_c));
        if (rd[2] !== exp_i)
            abort_run($sformatf("FAILED i: got 0x%0h, expected 0x%0h", rd[2], exp_i));
    endtask

    task automatic check_vec(input logic [1:0] exp_vec);
        logic [31:0] rd;
        apb_read(REG_STATUS, rd);
        if (rd[6:5] !== exp_vec)
            abort_run($sformatf("FAILED intvec: got 0x%0h, expected 0x%0h", rd[6:5], exp_vec));
    endtask

    task automatic check_state(input logic exp_busy, input logic exp_halt);
        logic [31:0] rd;
        apb_read(REG_STATUS, rd);
        if (rd[0] !== exp_busy)
            abort_run($sformatf("FAILED busy: got 0x%0h, expected 0x%0h", rd[0], exp_busy));
        if (rd[1] !== exp_halt)
            abort_run($sformatf("FAILED halt: got 0x%0h, expected 0x%0h", rd[1], exp_halt));
    endtask

    task automatic wait_idle();
        logic [31:0] rd;
        int          n;
        n = 0;
        apb_read(REG_STATUS, rd);
        while (rd[0] && n < TIMEOUT) begin
            n++;
            apb_read(REG_STATUS, rd);
        end
        if (rd[0]) abort_run("sequencer stayed busy");
    endtask

    task automatic wait_intvec();
        logic [31:0] rd;
        int          n;
        n = 0;
        apb_read(REG_STATUS, rd);
        while (rd[6:5] == 2'b00 && n < TIMEOUT) begin
            n++;
            apb_read(REG_STATUS, rd);
        end
        if (rd[6:5] == 2'b00) abort_run("interrupt was never taken");
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(negedge clk);
        while (rst && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (rst) abort_run("reset never released");
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        wait_reset_release();
        m_a = 8'd0;
        m_b = 8'd0;
        m_z = 1'b0;
        m_c = 1'b0;
        m_i = 1'b1;
    endtask

    task automatic load_operand(input logic [7:0] value);
        logic err;
        int   waits;
        apb_write(REG_OPERAND, 32'(value), err, waits);
        check_err(err, 1'b0);
    endtask

    task automatic exec_opcode(input op_e op);
        logic err;
        int   waits;
        apb_write(REG_OPCODE, 32'(op), err, waits);
        check_err(err, 1'b0);
        wait_idle();
    endtask

    // expected ALU results from the arithmetic rules
    task automatic alu_model(input op_e op);
        int sum;
        case (op)
            OP_ADDA: begin
                sum = int'(m_a) + int'(m_b);
                m_c = (sum > 255);
                m_a = 8'(sum);
            end
            OP_SUBA: begin
                m_c = (m_a < m_b);  // borrow
                m_a = m_a - m_b;
            end
            default: begin
                m_c = 1'b0;
                m_a = m_a & m_b;
            end
        endcase
        m_z = (m_a == 8'd0);
    endtask

    task automatic run_alu(input op_e op);
        exec_opcode(op);
        alu_model(op);
        check_acc(m_a, m_b);
        check_flags(m_z, m_c, m_i);
    endtask

    task automatic check_reset_values();
        check_state(1'b0, 1'b0);
        check_flags(1'b0, 1'b0, 1'b1);
        check_vec(2'b00);
        check_acc(8'd0, 8'd0);
    endtask

    task automatic run_alu_sequence();
        for (int k = 0; k < 4; k++) begin
            m_a = 8'($urandom);
            m_b = 8'($urandom);
            load_operand(m_a);
            exec_opcode(OP_LDA);
            load_operand(m_b);
            exec_opcode(OP_LDB);
            check_acc(m_a, m_b);
            run_alu(OP_ADDA);
            run_alu(OP_SUBA);
            run_alu(OP_ANDA);
        end
    endtask

    task automatic run_swap_and_delay();
        logic [7:0] tmp;
        logic [7:0] d;
        logic       err;
        int         waits;
        exec_opcode(OP_SWAP);
        tmp = m_a;
        m_a = m_b;
        m_b = tmp;
        check_acc(m_a, m_b);
        d = 8'(4 + $urandom % 60);
        load_operand(d);
        apb_write(REG_OPCODE, 32'(OP_DLY), err, waits);
        check_err(err, 1'b0);
        // next opcode must sit in the access phase until the delay is over
        apb_write(REG_OPCODE, 32'(OP_NOP), err, waits);
        check_err(err, 1'b0);
        if (waits < int'(d))
            abort_run($sformatf("opcode after DLY held %0d cycles, delay was %0d", waits, d));
        wait_idle();
        check_acc(m_a, m_b);
    endtask

    task automatic run_interrupts();
        exec_opcode(OP_CLI);
        m_i = 1'b0;
        check_flags(m_z, m_c, m_i);
        @(posedge clk);
        irq_n <= 1'b0;  // level IRQ now unmasked
        wait_intvec();
        wait_idle();
        m_i = 1'b1;
        check_vec(2'b01);
        check_flags(m_z, m_c, m_i);
        @(posedge clk);
        irq_n <= 1'b1;
        exec_opcode(OP_RTI);
        m_i = 1'b0;
        check_vec(2'b00);
        check_flags(m_z, m_c, m_i);
        exec_opcode(OP_SEI);
        m_i = 1'b1;
        check_flags(m_z, m_c, m_i);
        @(posedge clk);
        nmi_n <= 1'b0;  // edge ignores the mask
        wait_intvec();
        wait_idle();
        check_vec(2'b10);
        check_flags(m_z, m_c, m_i);
        @(posedge clk);
        nmi_n <= 1'b1;
        exec_opcode(OP_RTI);
        m_i = 1'b0;
        check_vec(2'b00);
        check_acc(m_a, m_b);
    endtask

    task automatic run_illegal_halt();
        logic [7:0] bad;
        logic       err;
        int         waits;
        bad = 8'hE0 | 8'($urandom % 16);  // nothing decoded in 0xE0..0xEF
        apb_write(REG_OPCODE, 32'(bad), err, waits);
        check_err(err, 1'b1);
        check_state(1'b0, 1'b1);
        apb_write(REG_OPCODE, 32'(OP_NOP), err, waits);
        check_err(err, 1'b1);
        check_state(1'b0, 1'b1);
        pulse_reset();
        check_reset_values();
        m_a = 8'($urandom);
        load_operand(m_a);
        exec_opcode(OP_LDA);
        check_acc(m_a, m_b);
    endtask

    initial begin
        rst_req = 1'b0;
        nmi_n   = 1'b1;
        irq_n   = 1'b1;
        paddr   = 4'h0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = 32'd0;
        m_a     = 8'd0;
        m_b     = 8'd0;
        m_z     = 1'b0;
        m_c     = 1'b0;
        m_i     = 1'b1;
        void'($urandom(32'h2ca2));
        wait_reset_release();
        check_reset_values();
        run_alu_sequence();
        run_swap_and_delay();
        run_interrupts();
        run_illegal_halt();
        @(negedge clk);
        if (u_useq_top.u_assertions.fail_cnt != 0) begin
            abort_run("a bound assertion failed");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/useq_assertions.sv
//****************************************
// concurrent checks on the top level
// APB error timing, intvec, halt, busy
//****************************************
`timescale 1ns/1ps
`default_nettype none

module useq_assertions import useq_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              psel,
    input logic              penable,
    input logic              pready,
    input logic              pslverr,
    input logic              busy,
    input logic              halted,
    input logic [1:0]        intvec,
    input logic [STEP_W-1:0] step,
    input state_e            state
);

    int fail_cnt = 0;  // failed assertion count

    // error only on the completing cycle of an access
    a_err_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> psel && penable && pready)
        else begin
            $error("pslverr raised outside a completing access phase");
            fail_cnt++;
        end

    a_vec_legal: assert property (@(posedge clk) disable iff (rst)
        intvec != 2'b11)
        else begin
            $error("intvec shows both NMI and IRQ");
            fail_cnt++;
        end

    a_halt_frozen: assert property (@(posedge clk) disable iff (rst)
        halted |=> $stable(step))
        else begin
            $error("step counter moved while halted");
            fail_cnt++;
        end

    a_idle_not_busy: assert property (@(posedge clk) disable iff (rst)
        !(busy && state == S_IDLE))
        else begin
            $error("busy high in idle");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
//****************************************
// testbench clock, 10 ns period
// reset for 5 cycles, re-armed by rst_req
//****************************************
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 5
) (
    input  logic rst_req,
    output logic clk,
    output logic rst
);

    int rst_cnt = RST_CYCLES;  // reset held from time zero

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_req) rst_cnt <= RST_CYCLES;
        else if (rst_cnt != 0) rst_cnt <= rst_cnt - 1;
    end

    assign rst = (rst_cnt != 0);

endmodule

`default_nettype wire

// File: verilog/useq_top.sv
//****************************************
// sequencer top level
//****************************************
`timescale 1ns/1ps
`default_nettype none

module useq_top import useq_pkg::*; #(
    parameter int DLY_W = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        nmi_n,
    input  logic        irq_n,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    op_e               opcode;
    routine_e          routine;
    routine_e          cur_routine;
    alu_e              alu_op;
    uop_e              uop;
    logic [DLY_W-1:0]  operand;
    logic [STEP_W-1:0] step;
    logic [7:0]        acc_a;
    logic [7:0]        acc_b;
    logic [1:0]        vec_sel;
    logic [1:0]        intvec;
    logic              issue;
    logic              illegal;
    logic              sub_sel;
    logic              step_clr;
    logic              step_inc;
    logic              dly_load;
    logic              dly_zero;
    logic              exec;
    logic              busy;
    logic              halted;
    logic              do_wait;
    logic              last;
    logic              set_i;
    logic              clr_i;
    logic              z;
    logic              c;
    logic              i_flag;

    apb_host_if #(.DLY_W(DLY_W)) u_apb (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .busy(busy), .halted(halted), .z(z), .c(c),
        .i_flag(i_flag), .intvec(intvec), .acc_a(acc_a), .acc_b(acc_b),
        .issue(issue), .opcode(opcode), .operand(operand)
    );

    op_decode u_dec (
        .opcode(opcode), .routine(routine), .alu_op(alu_op),
        .sub_sel(sub_sel), .illegal(illegal)
    );

    useq_fsm u_fsm (
        .clk(clk), .rst(rst), .issue(issue), .illegal(illegal), .routine(routine),
        .nmi_n(nmi_n), .irq_n(irq_n), .i_flag(i_flag), .last(last),
        .do_wait(do_wait), .dly_zero(dly_zero), .cur_routine(cur_routine),
        .step_clr(step_clr), .step_inc(step_inc), .dly_load(dly_load),
        .exec(exec), .busy(busy), .halted(halted)
    );

    step_counter #(.STEP_W(STEP_W), .DLY_W(DLY_W)) u_step (
        .clk(clk), .rst(rst), .step_clr(step_clr), .step_inc(step_inc),
        .dly_load(dly_load), .operand(operand), .step(step), .dly_zero(dly_zero)
    );

    ucode_rom u_rom (
        .cur_routine(cur_routine), .step(step), .uop(uop), .do_wait(do_wait),
        .last(last), .set_i(set_i), .clr_i(clr_i), .vec_sel(vec_sel)
    );

    useq_datapath u_dp (
        .clk(clk), .rst(rst), .exec(exec), .uop(uop), .alu_op(alu_op),
        .sub_sel(sub_sel), .operand(operand[7:0]), .set_i(set_i), .clr_i(clr_i),
        .vec_sel(vec_sel), .acc_a(acc_a), .acc_b(acc_b), .z(z), .c(c),
        .i_flag(i_flag), .intvec(intvec)
    );

endmodule

`default_nettype wire

// File: verilog/apb_host_if.sv
//****************************************
// APB slave for the host
// opcode, operand, status, accumulators
//****************************************
`timescale 1ns/1ps
`default_nettype none

module apb_host_if import useq_pkg::*; #(
    parameter int DLY_W = 8  // at least 8, low byte feeds the datapath
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [3:0]       paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    input  logic             busy,
    input  logic             halted,
    input  logic             z,
    input  logic             c,
    input  logic             i_flag,
    input  logic [1:0]       intvec,
    input  logic [7:0]       acc_a,
    input  logic [7:0]       acc_b,
    output logic             issue,
    output op_e              opcode,
    output logic [DLY_W-1:0] operand
);

    op_e  opcode_q;
    logic issued;  // issue was last cycle, halt or busy now valid
    logic wr_op;

    assign wr_op = psel && pwrite && (paddr == REG_OPCODE);

    // accept once idle, finish one cycle later so pslverr sees the halt
    assign issue   = wr_op && penable && !busy && !halted && !issued;
    assign pready  = wr_op ? (issued || halted) : 1'b1;
    assign pslverr = wr_op && penable && halted;

    // decoder sees the new opcode already in the issue cycle
    assign opcode = issue ? op_e'(pwdata[7:0]) : opcode_q;

    always_ff @(posedge clk) begin
        if (rst) issued <= 1'b0;
        else issued <= issue;
    end

    always_ff @(posedge clk) begin
        if (issue) opcode_q <= op_e'(pwdata[7:0]);
        if (psel && penable && pwrite && paddr == REG_OPERAND) operand <= pwdata[DLY_W-1:0];
    end

    always_comb begin
        case (paddr)
            REG_OPCODE:  prdata = {24'd0, opcode_q};
            REG_OPERAND: prdata = 32'(operand);
            REG_STATUS:  prdata = {25'd0, intvec, c, z, i_flag, halted, busy};
            REG_ACC:     prdata = {16'd0, acc_b, acc_a};
            default:     prdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/useq_datapath.sv
//****************************************
// accumulators A and B, temp
// ALU, z/c flags, i mask, intvec
//****************************************
`timescale 1ns/1ps
`default_nettype none

module useq_datapath import useq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       exec,
    input  uop_e       uop,
    input  alu_e       alu_op,
    input  logic       sub_sel,
    input  logic [7:0] operand,
    input  logic       set_i,
    input  logic       clr_i,
    input  logic [1:0] vec_sel,
    output logic [7:0] acc_a,
    output logic [7:0] acc_b,
    output logic       z,
    output logic       c,
    output logic       i_flag,
    output logic [1:0] intvec
);

    logic [7:0] temp;
    logic [8:0] alu_res;  // bit 8 is carry or borrow
    uop_e       uop_eff;

    // LDA and LDB share the load row
    assign uop_eff = (uop == U_LDA && sub_sel) ? U_LDB : uop;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_res = {1'b0, acc_a} + {1'b0, acc_b};
            ALU_SUB: alu_res = {1'b0, acc_a} - {1'b0, acc_b};
            default: alu_res = {1'b0, acc_a & acc_b};  // and clears c
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_a  <= 8'd0;
            acc_b  <= 8'd0;
            z      <= 1'b0;
            c      <= 1'b0;
            i_flag <= 1'b1;  // masked out of reset
            intvec <= 2'b00;
        end else if (exec) begin
            case (uop_eff)
                U_LDA: acc_a <= operand;
                U_LDB: acc_b <= operand;
                U_ALU: begin
                    acc_a <= alu_res[7:0];
                    c     <= alu_res[8];
                    z     <= (alu_res[7:0] == 8'd0);
                end
                U_B2A:   acc_a  <= acc_b;
                U_T2B:   acc_b  <= temp;
                U_FLAGS: i_flag <= !sub_sel;  // SEI sets, CLI clears
                default: ;
            endcase
            if (set_i) begin
                i_flag <= 1'b1;
                intvec <= vec_sel;
            end
            if (clr_i) begin  // RTI
                i_flag <= 1'b0;
                intvec <= 2'b00;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exec && uop_eff == U_A2T) temp <= acc_a;
    end

endmodule

`default_nettype wire

// File: verilog/useq_fsm.sv
//****************************************
// sequencer state machine
// instruction start, interrupts, stall
// halt on illegal opcode
//****************************************
`timescale 1ns/1ps
`default_nettype none

module useq_fsm import useq_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  logic     illegal,
    input  routine_e routine,
    input  logic     nmi_n,
    input  logic     irq_n,
    input  logic     i_flag,
    input  logic     last,
    input  logic     do_wait,
    input  logic     dly_zero,
    output routine_e cur_routine,
    output logic     step_clr,
    output logic     step_inc,
    output logic     dly_load,
    output logic     exec,
    output logic     busy,
    output logic     halted
);

    state_e   state;
    state_e   state_nx;
    routine_e routine_nx;
    logic     nmi_l;     // nmi_n one cycle back
    logic     nmi_pend;
    logic     op_pend;   // opcode held behind an interrupt
    logic     start;
    logic     nmi_take;
    logic     op_take;

    always_comb begin
        state_nx   = state;
        routine_nx = cur_routine;
        start      = 1'b0;
        nmi_take   = 1'b0;
        op_take    = 1'b0;
        step_inc   = 1'b0;
        dly_load   = 1'b0;
        case (state)
            S_IDLE: begin
                // priority: bad opcode, NMI, IRQ, then the opcode itself
                if (issue && illegal) state_nx = S_HALT;
                else if (nmi_pend) begin
                    routine_nx = R_NMI;
                    nmi_take   = 1'b1;
                    start      = 1'b1;
                end else if (!irq_n && !i_flag) begin
                    routine_nx = R_IRQ;
                    start      = 1'b1;
                end else if (issue || op_pend) begin
                    routine_nx = routine;
                    op_take    = 1'b1;
                    start      = 1'b1;
                end
            end
            S_RUN: begin
                if (do_wait) begin
                    dly_load = 1'b1;
                    state_nx = S_WAIT;
                end else if (last) begin
                    if (op_pend) begin  // chain straight into the queued opcode
                        routine_nx = routine;
                        op_take    = 1'b1;
                        start      = 1'b1;
                    end else state_nx = S_IDLE;
                end else step_inc = 1'b1;
            end
            S_WAIT: begin
                if (dly_zero) begin
                    step_inc = 1'b1;
                    state_nx = S_RUN;
                end
            end
            default: state_nx = S_HALT;  // only reset leaves halt
        endcase
        if (start) state_nx = S_RUN;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            cur_routine <= R_NOP;
            nmi_l       <= 1'b1;
            nmi_pend    <= 1'b0;
            op_pend     <= 1'b0;
        end else begin
            state       <= state_nx;
            cur_routine <= routine_nx;
            nmi_l       <= nmi_n;
            op_pend     <= (op_pend || (issue && !illegal)) && !op_take;
            if (nmi_take) nmi_pend <= 1'b0;
            if (nmi_l && !nmi_n) nmi_pend <= 1'b1;  // falling edge wins
        end
    end

    assign step_clr = start;
    assign exec     = (state == S_RUN);
    assign busy     = (state == S_RUN) || (state == S_WAIT);
    assign halted   = (state == S_HALT);

endmodule

`default_nettype wire

// File: verilog/step_counter.sv
//****************************************
// microprogram step counter
// loadable delay down-counter
//****************************************
`timescale 1ns/1ps
`default_nettype none

module step_counter #(
    parameter int STEP_W = 2,
    parameter int DLY_W  = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              step_clr,
    input  logic              step_inc,
    input  logic              dly_load,
    input  logic [DLY_W-1:0]  operand,
    output logic [STEP_W-1:0] step,
    output logic              dly_zero
);

    logic [DLY_W-1:0] dly_cnt;

    always_ff @(posedge clk) begin
        if (rst) step <= '0;
        else if (step_clr) step <= '0;  // new routine starts at row 0
        else if (step_inc) step <= step + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) dly_cnt <= '0;
        else if (dly_load) dly_cnt <= operand;
        else if (dly_cnt != '0) dly_cnt <= dly_cnt - 1'b1;  // stops at zero
    end

    assign dly_zero = (dly_cnt == '0);

endmodule

`default_nettype wire

// File: verilog/ucode_rom.sv
//****************************************
// microcode table
// one row per routine and step
//****************************************
`timescale 1ns/1ps
`default_nettype none

module ucode_rom import useq_pkg::*; (
    input  routine_e          cur_routine,
    input  logic [STEP_W-1:0] step,
    output uop_e              uop,
    output logic              do_wait,
    output logic              last,
    output logic              set_i,
    output logic              clr_i,
    output logic [1:0]        vec_sel
);

    always_comb begin
        uop     = U_NONE;
        do_wait = 1'b0;
        last    = 1'b0;
        set_i   = 1'b0;
        clr_i   = 1'b0;
        vec_sel = 2'b00;
        case (cur_routine)
            R_LD: begin
                uop  = U_LDA;  // datapath picks A or B
                last = 1'b1;
            end
            R_ALU: begin
                uop  = U_ALU;
                last = 1'b1;
            end
            R_SWAP: begin
                // exchange through temp, one move per row
                if (step == STEP_W'(0)) uop = U_A2T;
                else if (step == STEP_W'(1)) uop = U_B2A;
                else begin
                    uop  = U_T2B;
                    last = 1'b1;
                end
            end
            R_DLY: begin
                if (step == STEP_W'(0)) do_wait = 1'b1;  // park on the delay timer
                else last = 1'b1;
            end
            R_MASK: begin
                uop  = U_FLAGS;
                last = 1'b1;
            end
            R_RTI: begin
                clr_i = 1'b1;
                last  = 1'b1;
            end
            R_NMI, R_IRQ: begin
                // row 0 is a spare entry slot, row 1 masks and records the source
                if (step != STEP_W'(0)) begin
                    set_i   = 1'b1;
                    vec_sel = (cur_routine == R_NMI) ? VEC_NMI : VEC_IRQ;
                    last    = 1'b1;
                end
            end
            default: last = 1'b1;  // R_NOP
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/op_decode.sv
//****************************************
// opcode to routine category
// illegal opcode detection
//****************************************
`timescale 1ns/1ps
`default_nettype none

module op_decode import useq_pkg::*; (
    input  op_e      opcode,
    output routine_e routine,
    output alu_e     alu_op,
    output logic     sub_sel,
    output logic     illegal
);

    // opcodes that run the same microcode share one category
    always_comb begin
        routine = R_NOP;
        illegal = 1'b0;
        case (opcode)
            OP_NOP:                    routine = R_NOP;
            OP_LDA, OP_LDB:            routine = R_LD;
            OP_ADDA, OP_SUBA, OP_ANDA: routine = R_ALU;
            OP_SWAP:                   routine = R_SWAP;
            OP_DLY:                    routine = R_DLY;
            OP_SEI, OP_CLI:            routine = R_MASK;
            OP_RTI:                    routine = R_RTI;
            default:                   illegal = 1'b1;  // sequencer halts
        endcase
    end

    assign alu_op  = alu_e'(opcode[1:0]);  // add, sub, and in the low bits
    assign sub_sel = opcode[0];            // LDB vs LDA, CLI vs SEI

endmodule

`default_nettype wire

// File: verilog/useq_pkg.sv
//****************************************
// shared types for the sequencer
// opcodes, routines, micro-ops, states
// register offsets and vector codes
//****************************************
`default_nettype none

package useq_pkg;

    localparam int STEP_W = 2;  // up to 4 rows per routine

    // host register map
    localparam logic [3:0] REG_OPCODE  = 4'h0;
    localparam logic [3:0] REG_OPERAND = 4'h4;
    localparam logic [3:0] REG_STATUS  = 4'h8;
    localparam logic [3:0] REG_ACC     = 4'hC;

    // written into intvec by the interrupt routines
    localparam logic [1:0] VEC_NMI = 2'b10;
    localparam logic [1:0] VEC_IRQ = 2'b01;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_LDA  = 8'h10,
        OP_LDB  = 8'h11,
        OP_ADDA = 8'h20,
        OP_SUBA = 8'h21,
        OP_ANDA = 8'h22,
        OP_SWAP = 8'h30,
        OP_DLY  = 8'h40,
        OP_SEI  = 8'h50,
        OP_CLI  = 8'h51,
        OP_RTI  = 8'h60
    } op_e;

    typedef enum logic [3:0] {
        R_NOP, R_LD, R_ALU, R_SWAP, R_DLY, R_MASK, R_RTI, R_NMI, R_IRQ
    } routine_e;

    // datapath micro-operation field of a microcode row
    typedef enum logic [2:0] {
        U_NONE, U_LDA, U_LDB, U_ALU, U_A2T, U_B2A, U_T2B, U_FLAGS
    } uop_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND} alu_e;

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_WAIT, S_HALT} state_e;

endpackage

`default_nettype wire
